// ==== common/obj_pkg.sv ====
/* shared definitions for the sprite layer
   geometry, scan register indices and the attribute word with its two
   board decodes. modules pull it in with a wildcard import */
package obj_pkg;

    // object RAM word address width
    localparam int obj_ramw  = 10;
    // sprite table size
    localparam int obj_n     = 64;
    localparam int obj_words = 4;
    localparam int obj_iw    = $clog2(obj_n);
    localparam int word_w    = $clog2(obj_words);
    // scanner list index, one entry per table word
    localparam int list_aw   = obj_iw + word_w;
    // vblank copy length, two extra clocks for the RAM read pipe
    localparam int dma_len   = obj_n * obj_words + 2;

    // fixed sprite size
    localparam int obj_h     = 16;
    localparam int vis_lines = 240;

    // line buffer
    localparam int line_w    = 512;
    localparam int line_aw   = $clog2(line_w);

    // gfx ROM, 32-bit words
    localparam int rom_aw    = 20;

    // scan register indices
    localparam logic [1:0] reg_xoff = 2'd0;
    localparam logic [1:0] reg_yoff = 2'd1;
    localparam logic [1:0] reg_ctrl = 2'd2;

    // attribute, normal board
    typedef struct packed {
        logic [1:0] shd;
        logic [4:0] prio;
        logic [4:0] pal;
        logic [1:0] rsv;
        logic       vflip;
        logic       hflip;
    } attr_nrm_t;

    // attribute, k44 board
    // fewer prio bits, wider palette
    typedef struct packed {
        logic [3:0] rsv;
        logic       shd;
        logic [1:0] prio;
        logic [6:0] pal;
        logic       vflip;
        logic       hflip;
    } attr_k44_t;

    typedef union packed {
        attr_nrm_t nrm;
        attr_k44_t k44;
    } obj_attr_u;

endpackage

// ==== common/obj_draw_if.sv ====
/* draw request from the sprite scanner to the line drawer
   one request in flight: draw pulses for a clock, busy answers */
`timescale 1ns/1ps

interface obj_draw_if
    import obj_pkg::*;
();

    // one-clock request strobe
    logic       draw;
    // high from the clock after draw until both halves are written
    logic       busy;
    // tile code from table word 2
    logic [13:0] code;
    // screen x after offset
    logic [8:0] xpos;
    // row inside the sprite, already flipped
    logic [3:0] ysub;
    obj_attr_u  attr;

    // scanner side
    modport scan (
        output draw, code, xpos, ysub, attr,
        input  busy
    );

    // line drawer side
    modport drawer (
        input  draw, code, xpos, ysub, attr,
        output busy
    );

endinterface

// ==== verilog/obj_ram.sv ====
/* sprite table RAM
   CPU port with per-byte writes, read-only port for the vblank DMA.
   both reads are registered, one clock of latency */
`timescale 1ns/1ps

module obj_ram
    import obj_pkg::*;
(
    input  logic                clk,

    // CPU side
    input  logic [obj_ramw-1:0] cpu_addr,
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          cpu_we,
    output logic [15:0]         cpu_q,

    // DMA side
    input  logic [obj_ramw-1:0] dma_addr,
    output logic [15:0]         dma_q
);

    // two byte lanes per word
    logic [1:0][7:0] mem [2**obj_ramw];

    // CPU port, read returns the old word on a write cycle
    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 2; lane++) begin
            if (cpu_we[lane]) begin
                mem[cpu_addr][lane] <= cpu_dout[lane*8 +: 8];
            end
        end
        cpu_q <= mem[cpu_addr];
    end

    // DMA port, never writes
    always_ff @(posedge clk) begin
        dma_q <= mem[dma_addr];
    end

endmodule

// ==== obj_scan/obj_scan.sv ====
/* sprite scanner
   holds the scan registers, copies the table into a private list when
   vblank starts and, from each hs, walks the list and sends the
   sprites that touch the next line to the line drawer */
`timescale 1ns/1ps

module obj_scan
    import obj_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                k44_en,

    // register bus
    input  logic                reg_cs,
    input  logic                cpu_we,
    input  logic [1:0]          mmr_addr,
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          cpu_dsn,

    // video timing
    input  logic                lvbl,
    input  logic                hs,
    input  logic [8:0]          vdump,

    // table copy
    output logic [obj_ramw-1:0] dma_addr,
    input  logic [15:0]         dma_q,
    output logic                dma_bsy,

    obj_draw_if.scan            dr
);

    logic [15:0]        xoff;
    logic [15:0]        yoff;
    logic [15:0]        ctrl;
    logic               lvbl_l;
    logic               hs_l;
    logic               hs_rise;
    logic [list_aw:0]   dma_cnt;
    logic [list_aw-1:0] dma_wa;
    logic               dma_wr;
    logic [15:0]        lst [obj_n][obj_words];
    logic               scanning;
    logic [obj_iw-1:0]  scan_idx;
    logic [8:0]         vline;
    logic [8:0]         dy;
    obj_attr_u          ent_attr;
    obj_attr_u          out_attr;
    logic               vflip;
    logic               hit;
    logic               issue;

    // byte-lane merge, strobes active low
    function automatic logic [15:0] merge(input logic [15:0] old,
                                          input logic [15:0] din,
                                          input logic [1:0]  dsn);
        logic [15:0] res;
        res = old;
        if (!dsn[0]) res[7:0] = din[7:0];
        if (!dsn[1]) res[15:8] = din[15:8];
        return res;
    endfunction

    // scan registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xoff <= '0;
            yoff <= '0;
            ctrl <= '0;
        end else if (reg_cs && cpu_we) begin
            case (mmr_addr)
                reg_xoff: xoff <= merge(xoff, cpu_dout, cpu_dsn);
                reg_yoff: yoff <= merge(yoff, cpu_dout, cpu_dsn);
                reg_ctrl: ctrl <= merge(ctrl, cpu_dout, cpu_dsn);
                default:  ;
            endcase
        end
    end

    // address k goes out while cnt is k, data lands one clock later
    assign dma_addr = obj_ramw'(dma_cnt[list_aw-1:0]);
    // wraps to the last entry when cnt reaches the table size
    assign dma_wa   = dma_cnt[list_aw-1:0] - list_aw'(1);
    assign dma_wr   = dma_bsy && dma_cnt != '0 &&
                      dma_cnt <= (list_aw+1)'(obj_n * obj_words);

    // vblank copy, started by lvbl falling with ctrl bit 0 set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lvbl_l  <= 1'b0;
            dma_bsy <= 1'b0;
            dma_cnt <= '0;
        end else begin
            lvbl_l <= lvbl;
            if (dma_bsy) begin
                dma_cnt <= dma_cnt + (list_aw+1)'(1);
                if (dma_cnt == (list_aw+1)'(dma_len - 1)) dma_bsy <= 1'b0;
            end else if (lvbl_l && !lvbl && ctrl[0]) begin
                dma_bsy <= 1'b1;
                dma_cnt <= '0;
            end
        end
    end

    // private list, word index in the low bits
    always_ff @(posedge clk) begin
        if (dma_wr) lst[dma_wa[list_aw-1:word_w]][dma_wa[word_w-1:0]] <= dma_q;
    end

    assign hs_rise  = hs && !hs_l;

    // row inside the sprite for the line being prepared
    assign ent_attr = lst[scan_idx][3];
    assign dy       = vline - yoff[8:0] - lst[scan_idx][0][8:0];
    assign hit      = dy < 9'(obj_h);
    // vflip sits in bit 1 in both views
    assign vflip    = ent_attr.nrm.vflip;

    // clear the unused bits of whichever view is active
    always_comb begin
        out_attr = ent_attr;
        if (k44_en) out_attr.k44.rsv = '0;
        else        out_attr.nrm.rsv = '0;
    end

    // only one request at a time, never into a busy drawer
    assign issue = scanning && hit && !dr.busy && !dr.draw && !hs_rise;

    // list walk, restarted at every hs
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_l     <= 1'b0;
            scanning <= 1'b0;
            scan_idx <= '0;
            vline    <= '0;
            dr.draw  <= 1'b0;
        end else begin
            hs_l <= hs;
            if (hs_rise) begin
                scanning <= 1'b1;
                scan_idx <= '0;
                vline    <= vdump + 9'd1;
                dr.draw  <= 1'b0;
            end else begin
                dr.draw <= issue;
                // a hit holds the walk until the drawer takes it
                if (scanning && (!hit || issue)) begin
                    if (scan_idx == obj_iw'(obj_n - 1)) scanning <= 1'b0;
                    else scan_idx <= scan_idx + obj_iw'(1);
                end
            end
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        if (issue) begin
            dr.code <= lst[scan_idx][2][13:0];
            dr.xpos <= lst[scan_idx][1][8:0] - xoff[8:0];
            dr.ysub <= vflip ? ~dy[3:0] : dy[3:0];
            dr.attr <= out_attr;
        end
    end

    // handshake across both modules
    assert property (@(posedge clk) disable iff (!arst_n) dr.draw |-> !dr.busy)
        else $error("draw raised while the line drawer is busy");

    // the whole copy fits inside vertical blank
    assert property (@(posedge clk) disable iff (!arst_n)
                     $rose(dma_bsy) |-> vdump >= 9'(vis_lines))
        else $error("sprite DMA started outside vblank");

endmodule

// ==== obj_draw/obj_line_draw.sv ====
/* sprite line drawer
   fetches two 32-bit ROM words per request, decodes 8 pixels from each
   into the back half of a double line buffer, and reads the front half
   out with hdump, clearing each entry behind the beam */
`timescale 1ns/1ps

module obj_line_draw
    import obj_pkg::*;
(
    input  logic              clk,
    input  logic              arst_n,
    input  logic              pxl_cen,
    input  logic              hs,
    input  logic [8:0]        hdump,
    input  logic              k44_en,

    obj_draw_if.drawer        dr,

    // gfx ROM, variable latency
    output logic [rom_aw-1:0] rom_addr,
    output logic              rom_cs,
    input  logic              rom_ok,
    input  logic [31:0]       rom_data,

    // readout, {pal, pen}
    output logic [10:0]       buf_pxl,
    output logic [15:0]       buf_attr
);

    // entry is {attr, pal, pen}, pen 0 means empty
    logic [26:0]        lbuf [2][line_w];
    logic               hs_l;
    logic               hs_rise;
    logic               rd_half;
    logic               pix_en;
    logic               drop;
    logic               half;
    logic               accept;
    logic               pix_wr;
    logic [2:0]         col;
    logic [3:0]         colx;
    logic [3:0]         pen;
    logic [8:0]         xpos_r;
    obj_attr_u          attr_r;
    logic [31:0]        data_r;
    logic [6:0]         pal;
    logic [line_aw-1:0] wr_addr;
    logic [26:0]        wr_cur;

    // pen of pixel i, packed nibbles or one plane per byte
    function automatic logic [3:0] pen_of(input logic [31:0] d,
                                          input logic [2:0]  i,
                                          input logic        packed_m);
        logic [3:0] p;
        if (packed_m) begin
            p = d[{i, 2'b00} +: 4];
        end else begin
            p = {d[{2'd3, i}], d[{2'd2, i}], d[{2'd1, i}], d[{2'd0, i}]};
        end
        return p;
    endfunction

    assign hs_rise = hs && !hs_l;
    // low address bit selects the sprite half
    assign half    = rom_addr[0];
    assign dr.busy = rom_cs | pix_en;
    assign accept  = dr.draw && !dr.busy && !hs_rise;

    // current pixel
    assign pen     = pen_of(data_r, col, k44_en);
    assign colx    = attr_r.nrm.hflip ? ~{half, col} : {half, col};
    assign wr_addr = line_aw'(xpos_r + {5'd0, colx});
    assign wr_cur  = lbuf[~rd_half][wr_addr];
    assign pal     = k44_en ? attr_r.k44.pal : {2'b00, attr_r.nrm.pal};
    // earlier table entries already there win
    assign pix_wr  = pix_en && !hs_rise && pen != 4'd0 && wr_cur[3:0] == 4'd0;

    // fetch and pixel sequencing
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_l     <= 1'b0;
            rd_half  <= 1'b0;
            rom_cs   <= 1'b0;
            rom_addr <= '0;
            pix_en   <= 1'b0;
            drop     <= 1'b0;
            col      <= '0;
        end else begin
            hs_l <= hs;
            if (hs_rise) rd_half <= ~rd_half;
            if (rom_cs) begin
                // a pending read still completes, but its data is discarded
                if (rom_ok) begin
                    rom_cs <= 1'b0;
                    if (drop || hs_rise) begin
                        drop <= 1'b0;
                    end else begin
                        pix_en <= 1'b1;
                        col    <= '0;
                    end
                end else if (hs_rise) begin
                    drop <= 1'b1;
                end
            end else if (pix_en) begin
                if (hs_rise) begin
                    pix_en <= 1'b0;
                end else begin
                    col <= col + 3'd1;
                    if (col == 3'd7) begin
                        pix_en <= 1'b0;
                        // second word of the row
                        if (!half) begin
                            rom_cs      <= 1'b1;
                            rom_addr[0] <= 1'b1;
                        end
                    end
                end
            end else if (accept) begin
                rom_cs   <= 1'b1;
                // code*32 + ysub*2 + half
                rom_addr <= rom_aw'({dr.code, dr.ysub, 1'b0});
            end
        end
    end

    // request payload and ROM word
    always_ff @(posedge clk) begin
        if (accept) begin
            xpos_r <= dr.xpos;
            attr_r <= dr.attr;
        end
        if (rom_cs && rom_ok) data_r <= rom_data;
    end

    // back half gets pixels, front half is read and erased
    always_ff @(posedge clk) begin
        if (pix_wr) lbuf[~rd_half][wr_addr] <= {attr_r, pal, pen};
        if (pxl_cen) begin
            {buf_attr, buf_pxl} <= lbuf[rd_half][hdump];
            lbuf[rd_half][hdump] <= '0;
        end
    end

    // ROM request is held until acknowledged
    assert property (@(posedge clk) disable iff (!arst_n)
                     rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr))
        else $error("ROM request changed before rom_ok");

endmodule

// ==== verilog/obj_video.sv ====
/* sprite layer top level
   object RAM, scanner and line drawer, plus the output stage that
   applies shadow, priority and the layer enable. k44_en picks the board
   variant for ROM order and attribute decode */
`timescale 1ns/1ps

module obj_video
    import obj_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                k44_en,
    input  logic                pxl_cen,
    input  logic [8:0]          hdump,
    input  logic [8:0]          vdump,
    input  logic                hs,
    input  logic                lvbl,
    input  logic                ram_cs,
    input  logic                reg_cs,
    input  logic                cpu_we,
    input  logic [obj_ramw-1:0] cpu_addr,
    input  logic [1:0]          mmr_addr,
    input  logic [15:0]         cpu_dout,
    input  logic [1:0]          cpu_dsn,
    output logic [15:0]         cpu_din,
    output logic                dma_bsy,
    output logic [rom_aw-1:0]   rom_addr,
    output logic                rom_cs,
    input  logic                rom_ok,
    input  logic [31:0]         rom_data,
    input  logic                gfx_en,
    output logic [8:0]          pxl,
    output logic [4:0]          prio,
    output logic [1:0]          shd
);

    logic [1:0]          ram_we;
    logic [obj_ramw-1:0] dma_addr;
    logic [15:0]         dma_q;
    logic [10:0]         buf_pxl;
    logic [15:0]         buf_attr;
    obj_attr_u           oa;
    logic [3:0]          pen;
    logic [1:0]          shd_raw;
    logic                pen15;

    obj_draw_if dr ();

    // byte strobes are active low
    assign ram_we = {2{ram_cs & cpu_we}} & ~cpu_dsn;

    obj_ram u_ram (
        .clk      ( clk      ),
        .cpu_addr ( cpu_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_we   ( ram_we   ),
        .cpu_q    ( cpu_din  ),
        .dma_addr ( dma_addr ),
        .dma_q    ( dma_q    )
    );

    obj_scan u_scan (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .k44_en   ( k44_en   ),
        .reg_cs   ( reg_cs   ),
        .cpu_we   ( cpu_we   ),
        .mmr_addr ( mmr_addr ),
        .cpu_dout ( cpu_dout ),
        .cpu_dsn  ( cpu_dsn  ),
        .lvbl     ( lvbl     ),
        .hs       ( hs       ),
        .vdump    ( vdump    ),
        .dma_addr ( dma_addr ),
        .dma_q    ( dma_q    ),
        .dma_bsy  ( dma_bsy  ),
        .dr       ( dr       )
    );

    obj_line_draw u_draw (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .hs       ( hs       ),
        .hdump    ( hdump    ),
        .k44_en   ( k44_en   ),
        .dr       ( dr       ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .rom_ok   ( rom_ok   ),
        .rom_data ( rom_data ),
        .buf_pxl  ( buf_pxl  ),
        .buf_attr ( buf_attr )
    );

    // shadow shows only through pen 15, which then turns transparent
    assign oa      = buf_attr;
    assign pen     = buf_pxl[3:0];
    assign shd_raw = k44_en ? {1'b0, oa.k44.shd} : oa.nrm.shd;
    assign pen15   = &pen && shd_raw != 2'b00;

    // output register, second clock after the pxl_cen read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl  <= '0;
            prio <= '0;
            shd  <= '0;
        end else begin
            shd  <= pen15 ? shd_raw : 2'b00;
            // k44 keeps two prio bits in the middle
            prio <= k44_en ? {1'b1, oa.k44.prio, 2'b00} : oa.nrm.prio;
            pxl  <= gfx_en ? {buf_pxl[8:4], pen15 ? 4'd0 : pen} : 9'd0;
        end
    end

endmodule

// ==== testbench/obj_video_tb.sv ====
/* testbench for the sprite layer top level
   makes 384x264 video timing, drives the CPU bus, answers ROM reads after
   a random delay and checks RAM readback, DMA length and every visible
   pixel against a model of the table, registers and graphics */
`timescale 1ns/1ps

module obj_video_tb;

    logic        clk = 1'b0;
    logic        arst_n = 1'b0;
    logic        k44_en, pxl_cen = 1'b0, hs = 1'b0, lvbl = 1'b1;
    logic [8:0]  hdump = '0, vdump = '0;
    logic        ram_cs, reg_cs, cpu_we, gfx_en;
    logic [9:0]  cpu_addr;
    logic [1:0]  mmr_addr, cpu_dsn;
    logic [15:0] cpu_dout, cpu_din;
    logic        dma_bsy, rom_cs, rom_ok = 1'b0;
    logic [19:0] rom_addr;
    logic [31:0] rom_data = '0;
    logic [8:0]  pxl;
    logic [4:0]  prio;
    logic [1:0]  shd;

    int seed = 65;
    int errors = 0;
    // model state
    logic [15:0] ram_m [1024];
    int xoff_m, yoff_m;
    // monitor state
    int cyc = 0, fall_cyc = -10, run_len = 0, dma_starts = 0, dma_done = 0;
    logic bsy_prev = 1'b0, chk_en = 1'b0;
    logic timed_out = 1'b0;
    logic [2:0] rom_wait = '0;
    logic p1_cen = 1'b0, p2_cen = 1'b0;
    logic [8:0] p1_h, p1_v, p2_h, p2_v;

    obj_video uut (
        .clk(clk), .arst_n(arst_n), .k44_en(k44_en), .pxl_cen(pxl_cen),
        .hdump(hdump), .vdump(vdump), .hs(hs), .lvbl(lvbl),
        .ram_cs(ram_cs), .reg_cs(reg_cs), .cpu_we(cpu_we), .cpu_addr(cpu_addr),
        .mmr_addr(mmr_addr), .cpu_dout(cpu_dout), .cpu_dsn(cpu_dsn), .cpu_din(cpu_din),
        .dma_bsy(dma_bsy), .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_ok(rom_ok),
        .rom_data(rom_data), .gfx_en(gfx_en), .pxl(pxl), .prio(prio), .shd(shd)
    );

    always #20 clk = ~clk;

    // graphics ROM contents, a fixed scramble of the address
    function automatic logic [31:0] rom_word(input logic [19:0] a);
        logic [31:0] x;
        x = {12'h000, a} * 32'h9E37_79B1;
        x = x ^ (x >> 15) ^ {a[7:0], 24'h5A3C00};
        return x;
    endfunction

    // pen of column i within one ROM word
    function automatic logic [3:0] pen_at(input logic [31:0] d, input int i, input logic k44);
        logic [3:0] p;
        if (k44) begin
            p = d[i*4 +: 4];
        end else begin
            for (int b = 0; b < 4; b++) p[b] = d[b*8 + i];
        end
        return p;
    endfunction

    // expected {pxl, prio, shd} for the pixel read at h on line vd
    function automatic logic [15:0] expect_pixel(input int h, input int vd,
                                                 input logic k44, input logic gfx);
        int vline, dy, dx, c, ysub;
        logic [15:0] a;
        logic [3:0] pen, p;
        logic [6:0] pal;
        logic [1:0] sh;
        logic [4:0] pr;
        logic found;
        // halves swap at hs, so the left part still shows the older line
        vline = h >= 320 ? vd : vd - 1;
        found = 1'b0;
        pen = 4'd0;
        a = '0;
        for (int i = 0; i < 64 && !found; i++) begin
            dy = (vline - yoff_m - int'(ram_m[i*4][8:0])) & 511;
            dx = (h - int'(ram_m[i*4+1][8:0]) + xoff_m) & 511;
            if (dy < 16 && dx < 16) begin
                a    = ram_m[i*4+3];
                ysub = a[1] ? 15 - dy : dy;
                c    = a[0] ? 15 - dx : dx;
                p    = pen_at(rom_word(20'(int'(ram_m[i*4+2][13:0]) * 32 + ysub * 2 + c / 8)),
                              c % 8, k44);
                if (p != 4'd0) begin
                    found = 1'b1;
                    pen = p;
                end
            end
        end
        if (!found) a = '0;
        pal = k44 ? a[8:2] : {2'b00, a[8:4]};
        sh  = k44 ? {1'b0, a[11]} : a[15:14];
        pr  = k44 ? {1'b1, a[10:9], 2'b00} : a[13:9];
        // shadow only through pen 15
        if (pen == 4'd15 && sh != 2'b00) pen = 4'd0;
        else sh = 2'b00;
        return {gfx ? {pal[4:0], pen} : 9'd0, pr, sh};
    endfunction

    // video timing, hdump steps on the clock after each pxl_cen
    always @(posedge clk) begin : video_timing
        logic [8:0] nh, nv;
        cyc <= cyc + 1;
        if (pxl_cen) begin
            pxl_cen <= 1'b0;
            nh = hdump == 9'd383 ? 9'd0 : hdump + 9'd1;
            nv = hdump != 9'd383 ? vdump : (vdump == 9'd263 ? 9'd0 : vdump + 9'd1);
            hdump <= nh;
            vdump <= nv;
            hs    <= nh >= 9'd320 && nh < 9'd352;
            lvbl  <= nv < 9'd240;
            if (lvbl && nv >= 9'd240) fall_cyc <= cyc;
        end else begin
            pxl_cen <= 1'b1;
        end
    end

    // DMA length and start monitor
    always @(posedge clk) begin
        bsy_prev <= dma_bsy;
        if (dma_bsy && !bsy_prev) begin
            run_len <= 1;
            dma_starts <= dma_starts + 1;
            assert (cyc == fall_cyc + 2) else begin
                errors++;
                $display("Fail at %0t: DMA started %0d clocks after lvbl fell",
                         $time, cyc - fall_cyc);
            end
        end else if (dma_bsy) begin
            run_len <= run_len + 1;
        end
        if (!dma_bsy && bsy_prev) begin
            dma_done <= dma_done + 1;
            assert (run_len == 258) else begin
                errors++;
                $display("Fail at %0t: dma_bsy high for %0d clocks, expected 258",
                         $time, run_len);
            end
        end
    end

    // ROM with 0 to 5 clocks of extra delay
    always @(posedge clk) begin
        if (rom_ok) begin
            rom_ok <= 1'b0;
        end else if (rom_cs) begin
            if (rom_wait == 3'd0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
            end else begin
                rom_wait <= rom_wait - 3'd1;
            end
        end else begin
            rom_wait <= 3'($unsigned($random(seed)) % 6);
        end
    end

    // pixel compare, two clocks behind each pxl_cen
    always @(posedge clk) begin : pixel_check
        logic [15:0] expv;
        p1_cen <= pxl_cen;
        p1_h   <= hdump;
        p1_v   <= vdump;
        p2_cen <= p1_cen;
        p2_h   <= p1_h;
        p2_v   <= p1_v;
        if (chk_en && p2_cen && p2_v >= 9'd2 && p2_v < 9'd240) begin
            expv = expect_pixel(int'(p2_h), int'(p2_v), k44_en, gfx_en);
            assert ({pxl, prio, shd} == expv) else begin
                errors++;
                $display("Fail at %0t: h %0d v %0d got pxl %h prio %h shd %h, expected %h %h %h",
                         $time, p2_h, p2_v, pxl, prio, shd, expv[15:7], expv[6:2], expv[1:0]);
            end
        end
    end

    task automatic finish_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic ram_write(input int a, input logic [15:0] d, input logic [1:0] dsn);
        @(posedge clk);
        ram_cs   <= 1'b1;
        cpu_we   <= 1'b1;
        cpu_addr <= 10'(a);
        cpu_dout <= d;
        cpu_dsn  <= dsn;
        @(posedge clk);
        ram_cs  <= 1'b0;
        cpu_we  <= 1'b0;
        cpu_dsn <= 2'b11;
        if (!dsn[0]) ram_m[a][7:0] = d[7:0];
        if (!dsn[1]) ram_m[a][15:8] = d[15:8];
    endtask

    task automatic ram_check(input int a);
        @(posedge clk);
        ram_cs   <= 1'b1;
        cpu_addr <= 10'(a);
        @(posedge clk);
        ram_cs <= 1'b0;
        @(posedge clk);
        assert (cpu_din == ram_m[a]) else begin
            errors++;
            $display("Fail at %0t: RAM word %0d read %h, expected %h",
                     $time, a, cpu_din, ram_m[a]);
        end
    endtask

    task automatic reg_write(input logic [1:0] r, input logic [15:0] d);
        @(posedge clk);
        reg_cs   <= 1'b1;
        cpu_we   <= 1'b1;
        mmr_addr <= r;
        cpu_dout <= d;
        cpu_dsn  <= 2'b00;
        @(posedge clk);
        reg_cs  <= 1'b0;
        cpu_we  <= 1'b0;
        cpu_dsn <= 2'b11;
    endtask

    // waits for a full DMA that starts after the call
    task automatic wait_dma();
        int s0;
        int t;
        s0 = dma_starts;
        for (t = 0; t < 700000 && dma_starts == s0; t++) @(posedge clk);
        for (t = 0; t < 400 && dma_done != dma_starts; t++) @(posedge clk);
        if (dma_starts == s0 || dma_done != dma_starts) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout waiting for the sprite DMA to run");
        end
    endtask

    task automatic wait_line(input logic [8:0] v);
        int t;
        for (t = 0; t < 500000 && !timed_out && !(vdump == v && hdump == 9'd0); t++) begin
            @(posedge clk);
        end
        if (!timed_out && !(vdump == v && hdump == 9'd0)) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout waiting for line %0d", v);
        end
    endtask

    // 12 live sprites in a cluster so some overlap, the rest off screen
    task automatic build_table();
        for (int i = 0; i < 64; i++) begin
            if (i < 12) begin
                ram_write(i*4, 16'(20 + yoff_m + $unsigned($random(seed)) % 100), 2'b00);
                ram_write(i*4+1, 16'(40 + $unsigned($random(seed)) % 120), 2'b00);
            end else begin
                ram_write(i*4, 16'((400 - yoff_m) & 511), 2'b00);
                ram_write(i*4+1, 16'($random(seed)), 2'b00);
            end
            ram_write(i*4+2, 16'($random(seed)), 2'b00);
            ram_write(i*4+3, 16'($random(seed)), 2'b00);
        end
    endtask

    initial begin
        k44_en = 1'b0;
        gfx_en = 1'b1;
        ram_cs = 1'b0;
        reg_cs = 1'b0;
        cpu_we = 1'b0;
        cpu_addr = '0;
        mmr_addr = '0;
        cpu_dout = '0;
        cpu_dsn = 2'b11;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        assert (!dma_bsy && !rom_cs && pxl == 9'd0) else begin
            errors++;
            $display("Fail at %0t: outputs not idle after reset", $time);
        end

        // fill the whole RAM, then byte-lane writes with readback
        for (int a = 0; a < 1024; a++) ram_write(a, 16'($random(seed)), 2'b00);
        for (int n = 0; n < 200; n++) begin
            int a;
            a = int'($unsigned($random(seed)) % 1024);
            ram_write(a, 16'($random(seed)), 2'($random(seed)));
            ram_check(a);
        end

        reg_write(2'd2, 16'h0001);
        // normal board, k44 board, then layer disabled
        for (int mode = 0; mode < 3 && !timed_out; mode++) begin
            k44_en <= mode == 1;
            gfx_en <= mode != 2;
            xoff_m = int'($unsigned($random(seed)) % 32);
            yoff_m = int'($unsigned($random(seed)) % 16);
            reg_write(2'd0, 16'(xoff_m));
            reg_write(2'd1, 16'(yoff_m));
            build_table();
            wait_dma();
            wait_line(9'd2);
            chk_en <= 1'b1;
            wait_line(9'd240);
            chk_en <= 1'b0;
        end
        finish_run();
    end

endmodule

// ==== obj_video.f ====
common/obj_pkg.sv
common/obj_draw_if.sv
verilog/obj_ram.sv
obj_scan/obj_scan.sv
obj_draw/obj_line_draw.sv
verilog/obj_video.sv
testbench/obj_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the sprite layer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module obj_video_tb -f obj_video.f -o obj_video_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/obj_video_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1
